// File: verilog.f
+incdir+rtl
rtl/ndn_pkg.sv
rtl/fib_store_if.sv
rtl/prefix_hash.sv
rtl/fib_valid_store.sv
rtl/fib_insert.sv
rtl/fib_lpm.sv
rtl/fib_data_forward.sv
rtl/fib_table.sv
verif/tb_fib_table.sv

// File: verif/fib_cases.txt
# op prefix(hex, 64 bits) len(decimal) arg(decimal)
# arg: lkp expected match length, fwd 1 accept 0 reject, ins and rst ignore it
# Offer check and exact match
ins 123456789abcdef0 48 0
lkp 123456789abcdef0 48 48
# One name at three lengths, longest wins
ins c0a8010203040506 8 0
ins c0a8010203040506 16 0
ins c0a8010203040506 24 0
lkp c0a8010203040506 40 24
lkp c0a8010203040506 24 24
lkp c0a8010203040506 20 16
lkp c0a8010203040506 12 8
# Bits below the stored length do not matter
lkp c0a801ffffffffff 30 24
lkp c0a801000000000a 24 24
# No entry at any probed length
lkp 5555555555555555 20 0
# Length 0 request
lkp 123456789abcdef0 0 0
# PIT accepts, payload streams out
fwd 0a0b0c0d0e0f1011 12 1
lkp 0a0b0c0d0e0f1011 12 12
fwd feedfacecafebeef 56 1
lkp feedfacecafebeef 60 56
fwd 0102030405060708 40 1
lkp 0102030405060708 40 40
# PIT rejects, entry still stored
fwd 20010db800000001 28 0
lkp 20010db800000001 28 28
lkp 20010db8ffff0000 32 28
# Second reset clears the table
rst 0 0 0
lkp 123456789abcdef0 48 0
lkp c0a8010203040506 24 0
lkp 20010db800000001 28 0
lkp 0102030405060708 40 0
# Table usable again after reset
ins 0a0b0c0d0e0f1011 20 0
lkp 0a0b0c0d0e0f1011 20 20
fwd 0a0b0c0d0e0f1011 36 1
lkp 0a0b0c0d0e0f1011 36 36

// File: verif/tb_fib_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "ndn_macros.svh"

module tb_fib_table import ndn_pkg::*; ();

    localparam int timeout_cycles = 2000;

    logic        clk = 1'b0;
    logic        rst;
    logic        data_ready;
    prefix_t     data_in_prefix;
    prefix_len_t data_in_len;
    byte_t       data_in;
    logic        rejected;
    logic        start_send_to_pit;
    logic        fib_out_bit;
    prefix_t     pit_in_prefix;
    prefix_len_t pit_in_len;
    prefix_t     pit_out_prefix;
    prefix_len_t pit_out_len;
    logic        prefix_ready;
    logic        ready_for_data;
    logic        out_valid;
    byte_t       out_data;
    prefix_t     longest_matching_prefix;
    prefix_len_t longest_matching_prefix_len;
    logic        match_valid;

    // Presence bits predicted from the hash rule
    logic [(1 << `FIB_HASH_W)-1:0] model_tbl [`FIB_LENGTHS];

    // What the PIT side has seen so far
    byte_t got_bytes [$];
    int    rfd_count = 0;
    int    errors = 0;
    bit    aborted = 1'b0;

    fib_table uut (.*);

    // 4 ns period
    always #2 clk = ~clk;

    // Outputs sampled mid-cycle away from the drive edges
    always @(negedge clk) begin
        if (ready_for_data) begin
            rfd_count++;
        end
        if (out_valid) begin
            got_bytes.push_back(out_data);
        end
    end

    // Mask to len bits then XOR the seven chunks and the length
    function automatic fib_hash_t model_hash(input prefix_t p, input prefix_len_t len);
        prefix_t   m;
        fib_hash_t h;
        m = '0;
        for (int i = 0; i < len; i++) begin
            m[`FIB_PREFIX_W-1-i] = p[`FIB_PREFIX_W-1-i];
        end
        h = fib_hash_t'(len);
        for (int c = 0; c < 7; c++) begin
            h ^= fib_hash_t'(m >> (`FIB_HASH_W * c));
        end
        return h;
    endfunction

    // Longest set length in the model including false hits
    function automatic prefix_len_t model_lpm(input prefix_t p, input prefix_len_t len);
        for (int i = len; i >= 1; i--) begin
            if (model_tbl[i][model_hash(p, prefix_len_t'(i))]) begin
                return prefix_len_t'(i);
            end
        end
        return '0;
    endfunction

    task automatic flag_failure(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic compare_prefix(input prefix_t got, input prefix_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_len(input prefix_len_t got, input prefix_len_t exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // 16 cycles of reset and then every strobe must be low
    task automatic apply_reset();
        rst = 1'b1;
        for (int i = 0; i < `FIB_LENGTHS; i++) begin
            model_tbl[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (prefix_ready || ready_for_data || out_valid || match_valid) begin
            flag_failure("a strobe is high in the cycle after reset release");
        end
        @(posedge clk);
        #1;
    endtask

    // One data packet with the PIT answering after a random delay
    task automatic send_packet(input prefix_t p, input prefix_len_t l, input bit accept,
                               input int quiet);
        byte_t sent [$];
        int    delay;
        int    base_rfd;
        int    cycles;
        got_bytes.delete();
        base_rfd = rfd_count;
        data_ready = 1'b1;
        data_in_prefix = p;
        data_in_len = l;
        @(posedge clk);
        #1;
        data_ready = 1'b0;
        // Offer must sit exactly in the cycle after edge 1
        @(negedge clk);
        if (prefix_ready) begin
            flag_failure("prefix_ready came before the offer cycle");
        end
        @(negedge clk);
        if (!prefix_ready) begin
            flag_failure("prefix_ready missing one cycle after data_ready");
        end
        compare_prefix(pit_out_prefix, p, "pit_out_prefix");
        compare_len(pit_out_len, l, "pit_out_len");
        @(negedge clk);
        if (prefix_ready) begin
            flag_failure("prefix_ready lasted more than one cycle");
        end
        @(posedge clk);
        #1;
        delay = $urandom % 6;
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        model_tbl[l][model_hash(p, l)] = 1'b1;
        if (accept) begin
            start_send_to_pit = 1'b1;
            @(posedge clk);
            #1;
            start_send_to_pit = 1'b0;
            // Source supplies bytes back to back
            for (int k = 0; k < `FIB_PAYLOAD_BYTES; k++) begin
                data_in = byte_t'($urandom);
                sent.push_back(data_in);
                @(posedge clk);
                #1;
            end
            cycles = 0;
            while (got_bytes.size() < `FIB_PAYLOAD_BYTES && cycles < timeout_cycles) begin
                @(negedge clk);
                cycles++;
            end
            if (got_bytes.size() < `FIB_PAYLOAD_BYTES) begin
                $display("timeout: payload bytes did not all come out");
                aborted = 1'b1;
            end else begin
                // A few spare cycles catch extra bytes
                repeat (4) @(negedge clk);
                if (got_bytes.size() != `FIB_PAYLOAD_BYTES) begin
                    flag_failure($sformatf("%0d payload bytes came out", got_bytes.size()));
                end
                if (rfd_count != base_rfd + 1) begin
                    flag_failure("ready_for_data did not pulse exactly once");
                end
                for (int k = 0; k < `FIB_PAYLOAD_BYTES; k++) begin
                    compare_byte(got_bytes[k], sent[k], $sformatf("payload byte %0d", k));
                end
            end
            @(posedge clk);
            #1;
        end else begin
            // Reject arrives together with an accept and has to win
            rejected = 1'b1;
            start_send_to_pit = 1'b1;
            @(posedge clk);
            #1;
            rejected = 1'b0;
            start_send_to_pit = 1'b0;
            repeat (quiet) @(posedge clk);
            #1;
            if (rfd_count != base_rfd) begin
                flag_failure("ready_for_data pulsed after a reject");
            end
            if (got_bytes.size() != 0) begin
                flag_failure("out_valid came up after a reject");
            end
        end
    endtask

    // PIT lookup whose expected length is cross-checked with the model
    task automatic run_lookup(input prefix_t p, input prefix_len_t l, input prefix_len_t exp);
        int cycles;
        fib_out_bit = 1'b1;
        pit_in_prefix = p;
        pit_in_len = l;
        @(posedge clk);
        #1;
        fib_out_bit = 1'b0;
        cycles = 0;
        while (!match_valid && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!match_valid) begin
            $display("timeout: match_valid never came for a lookup");
            aborted = 1'b1;
        end else begin
            compare_prefix(longest_matching_prefix, p, "longest_matching_prefix");
            compare_len(longest_matching_prefix_len, exp, "longest_matching_prefix_len");
        end
        compare_len(exp, model_lpm(p, l), "case file length against the model");
        @(posedge clk);
        #1;
    endtask

    initial begin : main_flow
        int               fd;
        int               fields;
        int               seed;
        int               n_cases;
        int               case_errors;
        int               arg;
        logic [8*160-1:0] line;
        logic [8*8-1:0]   op;
        prefix_t          p;
        prefix_len_t      l;
        string            kind;

        seed = $urandom(32'h81a6);
        n_cases = 0;
        arg = 0;
        rst = 1'b1;
        data_ready = 1'b0;
        data_in_prefix = '0;
        data_in_len = '0;
        data_in = '0;
        rejected = 1'b0;
        start_send_to_pit = 1'b0;
        fib_out_bit = 1'b0;
        pit_in_prefix = '0;
        pit_in_len = '0;
        @(posedge clk);
        #1;
        apply_reset();

        fd = $fopen("verif/fib_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/fib_cases.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = '0;
            op = '0;
            if ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %h %d %d", op, p, l, arg);
                // Comment and blank lines skipped
                if (fields >= 3 && op != "#") begin
                    n_cases++;
                    case_errors = errors;
                    if (op == "ins") begin
                        kind = "insert";
                        send_packet(p, l, 1'b0, 4);
                    end else if (op == "fwd") begin
                        kind = (arg != 0) ? "forward accept" : "forward reject";
                        send_packet(p, l, arg != 0, 100);
                    end else if (op == "lkp") begin
                        kind = "lookup";
                        run_lookup(p, l, prefix_len_t'(arg));
                    end else if (op == "rst") begin
                        kind = "reset";
                        apply_reset();
                    end else begin
                        kind = "unknown";
                        flag_failure("unknown opcode in the case file");
                    end
                    $display("case %0d %s prefix %h len %0d: %s", n_cases, kind, p, l,
                             (errors == case_errors) ? "ok" : "failed");
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("%0d cases run, %0d errors", n_cases, errors);
        if (aborted || errors != 0 || n_cases == 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/fib_table.sv
`timescale 1ns/10ps
`default_nettype none

module fib_table import ndn_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // Data packet side
    input  logic        data_ready,
    input  prefix_t     data_in_prefix,
    input  prefix_len_t data_in_len,
    input  byte_t       data_in,
    // PIT verdict on an offered packet
    input  logic        rejected,
    input  logic        start_send_to_pit,
    // PIT lookup request
    input  logic        fib_out_bit,
    input  prefix_t     pit_in_prefix,
    input  prefix_len_t pit_in_len,
    // Offer and payload toward the PIT
    output prefix_t     pit_out_prefix,
    output prefix_len_t pit_out_len,
    output logic        prefix_ready,
    output logic        ready_for_data,
    output logic        out_valid,
    output byte_t       out_data,
    // Lookup result
    output prefix_t     longest_matching_prefix,
    output prefix_len_t longest_matching_prefix_len,
    output logic        match_valid
);

    // Write and read ports of the presence-bit table
    fib_store_if store_bus ();

    fib_valid_store u_store (
        .clk (clk),
        .rst (rst),
        .st  (store_bus.store)
    );

    // Every data packet gets inserted
    fib_insert u_insert (
        .clk            (clk),
        .rst            (rst),
        .data_ready     (data_ready),
        .data_in_prefix (data_in_prefix),
        .data_in_len    (data_in_len),
        .wr             (store_bus.writer)
    );

    fib_lpm u_lpm (
        .clk                         (clk),
        .rst                         (rst),
        .fib_out_bit                 (fib_out_bit),
        .pit_in_prefix               (pit_in_prefix),
        .pit_in_len                  (pit_in_len),
        .rd                          (store_bus.reader),
        .longest_matching_prefix     (longest_matching_prefix),
        .longest_matching_prefix_len (longest_matching_prefix_len),
        .match_valid                 (match_valid)
    );

    // Same data_ready as insertion, runs alongside it
    fib_data_forward u_forward (
        .clk               (clk),
        .rst               (rst),
        .data_ready        (data_ready),
        .rejected          (rejected),
        .start_send_to_pit (start_send_to_pit),
        .data_in_prefix    (data_in_prefix),
        .data_in_len       (data_in_len),
        .data_in           (data_in),
        .pit_out_prefix    (pit_out_prefix),
        .pit_out_len       (pit_out_len),
        .prefix_ready      (prefix_ready),
        .ready_for_data    (ready_for_data),
        .out_valid         (out_valid),
        .out_data          (out_data)
    );

endmodule

`default_nettype wire

// File: rtl/fib_data_forward.sv
`timescale 1ns/10ps
`default_nettype none

`include "ndn_macros.svh"

module fib_data_forward import ndn_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        data_ready,
    input  logic        rejected,
    input  logic        start_send_to_pit,
    input  prefix_t     data_in_prefix,
    input  prefix_len_t data_in_len,
    input  byte_t       data_in,
    output prefix_t     pit_out_prefix,
    output prefix_len_t pit_out_len,
    output logic        prefix_ready,
    output logic        ready_for_data,
    output logic        out_valid,
    output byte_t       out_data
);

    localparam int cnt_w = $clog2(`FIB_PAYLOAD_BYTES);
    localparam logic [cnt_w-1:0] last_byte = cnt_w'(`FIB_PAYLOAD_BYTES - 1);

    fwd_state_e       state;
    prefix_t          prefix_q;
    prefix_len_t      len_q;
    logic [cnt_w-1:0] byte_cnt;

    // PIT accept, a reject in the same cycle overrides it
    assign ready_for_data = (state == fwd_await_pit) && start_send_to_pit && !rejected;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= fwd_idle;
            byte_cnt       <= '0;
            prefix_ready   <= 1'b0;
            pit_out_prefix <= '0;
            pit_out_len    <= '0;
            out_valid      <= 1'b0;
        end else begin
            // Offer lasts one cycle, outputs read zero otherwise
            prefix_ready   <= (state == fwd_offer);
            pit_out_prefix <= (state == fwd_offer) ? prefix_q : '0;
            pit_out_len    <= (state == fwd_offer) ? len_q : '0;
            // Valid follows each sampled byte by one cycle
            out_valid      <= (state == fwd_transfer);
            case (state)
                fwd_idle: begin
                    if (data_ready) begin
                        state <= fwd_offer;
                    end
                end
                fwd_offer: state <= fwd_await_pit;
                // PIT may take any number of cycles to answer
                fwd_await_pit: begin
                    if (rejected) begin
                        state <= fwd_idle;
                    end else if (start_send_to_pit) begin
                        byte_cnt <= '0;
                        state    <= fwd_transfer;
                    end
                end
                // One byte per cycle, no stalls
                fwd_transfer: begin
                    if (byte_cnt == last_byte) begin
                        byte_cnt <= '0;
                        state    <= fwd_idle;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: state <= fwd_idle;
            endcase
        end
    end

    // Name of the packet being forwarded
    always_ff @(posedge clk) begin
        if (state == fwd_idle && data_ready) begin
            prefix_q <= data_in_prefix;
            len_q    <= data_in_len;
        end
    end

    // Payload output register
    always_ff @(posedge clk) begin
        if (state == fwd_transfer) begin
            out_data <= data_in;
        end
    end

    // Offer and payload phases never overlap
    a_offer_vs_payload : assert property (
        @(posedge clk) disable iff (rst)
        prefix_ready |-> !out_valid
    ) else $error("fib_data_forward: prefix_ready during payload transfer");

endmodule

`default_nettype wire

// File: rtl/fib_lpm.sv
`timescale 1ns/10ps
`default_nettype none

module fib_lpm import ndn_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         fib_out_bit,
    input  prefix_t      pit_in_prefix,
    input  prefix_len_t  pit_in_len,
    fib_store_if.reader  rd,
    output prefix_t      longest_matching_prefix,
    output prefix_len_t  longest_matching_prefix_len,
    output logic         match_valid
);

    lpm_state_e  state;
    prefix_t     req_prefix;
    prefix_len_t probe_len;
    fib_hash_t   hash;
    logic        probe_found;
    logic        probe_end;

    // Private hash unit, hashes the request at the current probe length
    prefix_hash u_hash (
        .clk    (clk),
        .rst    (rst),
        .prefix (req_prefix),
        .len    (probe_len),
        .hash   (hash)
    );

    // Store read address follows the probe
    assign rd.rd_len  = probe_len;
    assign rd.rd_hash = hash;

    // Length 0 never counts as a hit
    assign probe_found = rd.rd_hit && (probe_len != '0);

    // Stop on a hit, or when no shorter length is left
    assign probe_end = probe_found || (probe_len <= prefix_len_t'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state                       <= lpm_idle;
            probe_len                   <= '0;
            longest_matching_prefix     <= '0;
            longest_matching_prefix_len <= '0;
        end else begin
            case (state)
                // Request length is the first probe
                lpm_idle: begin
                    if (fib_out_bit) begin
                        probe_len <= pit_in_len;
                        state     <= lpm_hash_wait;
                    end
                end
                // Hash of (prefix, probe_len) registers here
                lpm_hash_wait: state <= lpm_probe;
                lpm_probe: begin
                    if (probe_end) begin
                        // Prefix goes back unmasked, length 0 when nothing hit
                        longest_matching_prefix     <= req_prefix;
                        longest_matching_prefix_len <= probe_found ? probe_len : '0;
                        state                       <= lpm_done;
                    end else begin
                        // Miss, try one bit shorter
                        probe_len <= probe_len - prefix_len_t'(1);
                        state     <= lpm_hash_wait;
                    end
                end
                lpm_done: state <= lpm_idle;
                default:  state <= lpm_idle;
            endcase
        end
    end

    // Request prefix held for the whole search
    always_ff @(posedge clk) begin
        if (state == lpm_idle && fib_out_bit) begin
            req_prefix <= pit_in_prefix;
        end
    end

    // One-cycle result strobe
    assign match_valid = (state == lpm_done);

    // Search only walks toward shorter prefixes
    a_probe_len_down : assert property (
        @(posedge clk) disable iff (rst)
        (state != lpm_idle) |=> (probe_len <= $past(probe_len))
    ) else $error("fib_lpm: probe length increased during a search");

endmodule

`default_nettype wire

// File: rtl/fib_insert.sv
`timescale 1ns/10ps
`default_nettype none

module fib_insert import ndn_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         data_ready,
    input  prefix_t      data_in_prefix,
    input  prefix_len_t  data_in_len,
    fib_store_if.writer  wr
);

    insert_state_e state;
    prefix_t       prefix_q;
    prefix_len_t   len_q;
    fib_hash_t     hash;

    // Control path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ins_idle;
        end else begin
            case (state)
                // New packets only accepted here
                ins_idle: begin
                    if (data_ready) begin
                        state <= ins_hash_wait;
                    end
                end
                // Hash register loads on this edge
                ins_hash_wait: state <= ins_write_bit;
                // Bit set on this edge, back to idle
                ins_write_bit: state <= ins_idle;
                default:       state <= ins_idle;
            endcase
        end
    end

    // Capture the arriving name while waiting
    always_ff @(posedge clk) begin
        if (state == ins_idle && data_ready) begin
            prefix_q <= data_in_prefix;
            len_q    <= data_in_len;
        end
    end

    // Private hash unit for the insert path
    prefix_hash u_hash (
        .clk    (clk),
        .rst    (rst),
        .prefix (prefix_q),
        .len    (len_q),
        .hash   (hash)
    );

    // Write strobe decoded straight from the state
    assign wr.wr_en   = (state == ins_write_bit);
    assign wr.wr_len  = len_q;
    assign wr.wr_hash = hash;

    // Each insertion sets exactly one bit
    a_single_write : assert property (
        @(posedge clk) disable iff (rst)
        wr.wr_en |=> !wr.wr_en
    ) else $error("fib_insert: wr_en held longer than one cycle");

endmodule

`default_nettype wire

// File: rtl/fib_valid_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "ndn_macros.svh"

module fib_valid_store import ndn_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    fib_store_if.store st
);

    localparam int buckets = 1 << `FIB_HASH_W;

    // One presence bit per (length, bucket) pair
    logic [buckets-1:0] valid_bits [`FIB_LENGTHS];

    // Table cleared on reset, otherwise only bits get set
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int l = 0; l < `FIB_LENGTHS; l++) begin
                valid_bits[l] <= '0;
            end
        end else if (st.wr_en) begin
            valid_bits[st.wr_len][st.wr_hash] <= 1'b1;
        end
    end

    // Read sees the table before any write on the same edge
    assign st.rd_hit = valid_bits[st.rd_len][st.rd_hash];

    // Row 0 stays empty, it encodes "no match" for the lookup side
    a_no_len_zero_write : assert property (
        @(posedge clk) disable iff (rst)
        st.wr_en |-> (st.wr_len != '0)
    ) else $error("fib_valid_store: write to reserved length 0");

endmodule

`default_nettype wire

// File: rtl/prefix_hash.sv
`timescale 1ns/10ps
`default_nettype none

`include "ndn_macros.svh"

module prefix_hash import ndn_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  prefix_t     prefix,
    input  prefix_len_t len,
    output fib_hash_t   hash
);

    prefix_t   masked;
    fib_hash_t folded;
    fib_hash_t hash_next;

    // Keep only the top len bits of the prefix
    // A length of 0 clears the whole word
    assign masked = prefix & ~({`FIB_PREFIX_W{1'b1}} >> len);

    // Fold into 10-bit chunks from bit 0 upward
    // The short top chunk lands in the low bits, zero-extended
    always_comb begin
        folded = '0;
        for (int b = 0; b < `FIB_PREFIX_W; b++) begin
            folded[b % `FIB_HASH_W] = folded[b % `FIB_HASH_W] ^ masked[b];
        end
    end

    // Length mixed in so equal masked words at different lengths spread apart
    assign hash_next = folded ^ fib_hash_t'(len);

    // One cycle of latency, hash of edge-n inputs valid after edge n
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hash <= '0;
        end else begin
            hash <= hash_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fib_store_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fib_store_if import ndn_pkg::*; ();

    // Write port, one bit set per strobe
    logic        wr_en;
    prefix_len_t wr_len;
    fib_hash_t   wr_hash;

    // Read port, hit is combinational from the table
    prefix_len_t rd_len;
    fib_hash_t   rd_hash;
    logic        rd_hit;

    // Insertion side
    modport writer (
        output wr_en,
        output wr_len,
        output wr_hash
    );

    // Lookup side
    modport reader (
        output rd_len,
        output rd_hash,
        input  rd_hit
    );

    // Presence-bit table
    modport store (
        input  wr_en,
        input  wr_len,
        input  wr_hash,
        input  rd_len,
        input  rd_hash,
        output rd_hit
    );

endinterface

`default_nettype wire

// File: rtl/ndn_pkg.sv
`default_nettype none

package ndn_pkg;

`include "ndn_macros.svh"

    // Datapath types
    typedef logic [`FIB_PREFIX_W-1:0] prefix_t;
    typedef logic [`FIB_LEN_W-1:0]    prefix_len_t;
    typedef logic [`FIB_HASH_W-1:0]   fib_hash_t;
    typedef logic [7:0]               byte_t;

    // Insertion FSM
    typedef enum logic [1:0] {
        ins_idle,
        ins_hash_wait,
        ins_write_bit
    } insert_state_e;

    // Longest-prefix-match FSM
    typedef enum logic [1:0] {
        lpm_idle,
        lpm_hash_wait,
        lpm_probe,
        lpm_done
    } lpm_state_e;

    // Forwarding FSM toward the PIT
    typedef enum logic [1:0] {
        fwd_idle,
        fwd_offer,
        fwd_await_pit,
        fwd_transfer
    } fwd_state_e;

endpackage

`default_nettype wire

// File: rtl/ndn_macros.svh
`ifndef NDN_MACROS_SVH
`define NDN_MACROS_SVH

// Name prefix width, left-aligned in the word
`define FIB_PREFIX_W 64

// Prefix length field width
`define FIB_LEN_W 6

// Bucket index width of the prefix hash
`define FIB_HASH_W 10

// One table row per possible prefix length
`define FIB_LENGTHS 64

// Payload bytes carried by each data packet
// Small value for short simulations
`define FIB_PAYLOAD_BYTES 64

`endif
